/* src/fxdiv_pkg.sv */
package fxdiv_pkg;

    // ************************************************************************
    // Widths and timing
    // ************************************************************************

    localparam int DATA_WIDTH     = 32;
    localparam int QUANTIZED_BITS = 10;                          // Fraction bits, Q22.10
    localparam int DIV_WIDTH      = DATA_WIDTH + QUANTIZED_BITS; // Scaled dividend
    localparam int COUNT_WIDTH    = $clog2(DIV_WIDTH + 1);
    localparam int LATENCY        = DIV_WIDTH + 4;               // Accept edge to valid_out

    // Quotient magnitude limits of the signed result range
    localparam logic [DIV_WIDTH-1:0] POS_LIMIT =
        (DIV_WIDTH'(1) << (DATA_WIDTH - 1)) - DIV_WIDTH'(1);
    localparam logic [DIV_WIDTH-1:0] NEG_LIMIT = DIV_WIDTH'(1) << (DATA_WIDTH - 1);

    // ************************************************************************
    // Types
    // ************************************************************************

    typedef enum logic [1:0] {
        idle,
        iterate,
        correct,
        finish
    } div_state_t;

    typedef enum logic [1:0] {
        res_normal,
        res_saturate,
        res_zero_div
    } result_kind_t;

endpackage

/* src/div_if.sv */
`timescale 1ns/1ns

interface div_if;

    logic                                start;
    logic [fxdiv_pkg::DIV_WIDTH-1:0]     dividend_mag;     // Already scaled
    logic [fxdiv_pkg::DATA_WIDTH-1:0]    divisor_mag;
    logic                                negate_quotient;
    logic                                negate_remainder;

    logic                                done;
    logic [fxdiv_pkg::DIV_WIDTH-1:0]     quotient_mag;
    logic [fxdiv_pkg::DATA_WIDTH-1:0]    remainder_mag;

    modport prep (
        output start, dividend_mag, divisor_mag, negate_quotient, negate_remainder
    );

    modport core (
        input  start, dividend_mag, divisor_mag,
        output done, quotient_mag, remainder_mag
    );

    // Divisor is read here for the divide-by-zero check
    modport format (
        input done, quotient_mag, remainder_mag, divisor_mag,
        input negate_quotient, negate_remainder
    );

endinterface

/* src/operand_prep.sv */
`timescale 1ns/1ns

module operand_prep (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   valid_in,
    input  logic signed [fxdiv_pkg::DATA_WIDTH-1:0] dividend,
    input  logic signed [fxdiv_pkg::DATA_WIDTH-1:0] divisor,
    input  logic                                   valid_out,
    output logic                                   busy,
    div_if.prep                                    div_bus
);

    logic [fxdiv_pkg::DATA_WIDTH-1:0] dividend_abs;
    logic [fxdiv_pkg::DATA_WIDTH-1:0] divisor_abs;
    logic                             accept;

    // Most negative input maps to 2**(DATA_WIDTH-1), still fits unsigned
    assign dividend_abs = dividend[fxdiv_pkg::DATA_WIDTH-1] ?
                          fxdiv_pkg::DATA_WIDTH'(-dividend) :
                          fxdiv_pkg::DATA_WIDTH'(dividend);
    assign divisor_abs  = divisor[fxdiv_pkg::DATA_WIDTH-1] ?
                          fxdiv_pkg::DATA_WIDTH'(-divisor) :
                          fxdiv_pkg::DATA_WIDTH'(divisor);

    assign accept = valid_in && !busy; // Strobes while busy are dropped

    // ************************************************************************
    // Control
    // ************************************************************************

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy          <= 1'b0;
            div_bus.start <= 1'b0;
        end else begin
            div_bus.start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (valid_out) begin
                busy <= 1'b0;
            end
        end
    end

    // ************************************************************************
    // Operand capture
    // ************************************************************************

    always_ff @(posedge clock) begin
        if (accept) begin
            div_bus.dividend_mag <= fxdiv_pkg::DIV_WIDTH'(dividend_abs)
                                    << fxdiv_pkg::QUANTIZED_BITS;
            div_bus.divisor_mag  <= divisor_abs;
            div_bus.negate_quotient  <= dividend[fxdiv_pkg::DATA_WIDTH-1] ^
                                        divisor[fxdiv_pkg::DATA_WIDTH-1];
            div_bus.negate_remainder <= dividend[fxdiv_pkg::DATA_WIDTH-1];
        end
    end

endmodule

/* src/nonrestoring_divider.sv */
`timescale 1ns/1ns

module nonrestoring_divider (
    input  logic clock,
    input  logic reset,
    div_if.core  div_bus
);

    fxdiv_pkg::div_state_t state, state_c;

    logic [fxdiv_pkg::COUNT_WIDTH-1:0]     count, count_c;
    logic signed [fxdiv_pkg::DATA_WIDTH+1:0] acc, acc_c;   // Partial remainder, 2 guard bits
    logic [fxdiv_pkg::DIV_WIDTH-1:0]       quo, quo_c;
    logic signed [fxdiv_pkg::DATA_WIDTH+1:0] shifted;
    logic signed [fxdiv_pkg::DATA_WIDTH+1:0] divisor_ext;

    assign divisor_ext = {2'b00, div_bus.divisor_mag};

    // ************************************************************************
    // State and data registers
    // ************************************************************************

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= fxdiv_pkg::idle;
            count <= '0;
        end else begin
            state <= state_c;
            count <= count_c;
        end
    end

    always_ff @(posedge clock) begin
        acc <= acc_c;
        quo <= quo_c;
    end

    // ************************************************************************
    // Iteration
    // ************************************************************************

    always_comb begin
        state_c = state;
        count_c = count;
        acc_c   = acc;
        quo_c   = quo;
        shifted = '0;

        case (state)
            fxdiv_pkg::idle: begin
                if (div_bus.start) begin
                    acc_c   = '0;
                    quo_c   = div_bus.dividend_mag; // Dividend shifts out as quotient shifts in
                    count_c = '0;
                    state_c = fxdiv_pkg::iterate;
                end
            end

            fxdiv_pkg::iterate: begin
                shifted = {acc[fxdiv_pkg::DATA_WIDTH:0], quo[fxdiv_pkg::DIV_WIDTH-1]};
                if (acc[fxdiv_pkg::DATA_WIDTH+1]) begin
                    acc_c = shifted + divisor_ext;  // Negative remainder adds
                end else begin
                    acc_c = shifted - divisor_ext;
                end
                quo_c   = {quo[fxdiv_pkg::DIV_WIDTH-2:0], ~acc_c[fxdiv_pkg::DATA_WIDTH+1]};
                count_c = count + 1'b1;
                if (count == fxdiv_pkg::COUNT_WIDTH'(fxdiv_pkg::DIV_WIDTH - 1)) begin
                    state_c = fxdiv_pkg::correct;
                end
            end

            fxdiv_pkg::correct: begin
                if (acc[fxdiv_pkg::DATA_WIDTH+1]) begin
                    acc_c = acc + divisor_ext;      // Restore final remainder
                end
                state_c = fxdiv_pkg::finish;
            end

            fxdiv_pkg::finish: begin
                state_c = fxdiv_pkg::idle;
            end

            default: begin
                state_c = fxdiv_pkg::idle;
            end
        endcase
    end

    assign div_bus.done          = (state == fxdiv_pkg::finish);
    assign div_bus.quotient_mag  = quo;
    assign div_bus.remainder_mag = acc[fxdiv_pkg::DATA_WIDTH-1:0]; // Non-negative after correct

endmodule

/* src/result_format.sv */
`timescale 1ns/1ns

module result_format (
    input  logic                                    clock,
    input  logic                                    reset,
    div_if.format                                   div_bus,
    output logic                                    valid_out,
    output logic signed [fxdiv_pkg::DATA_WIDTH-1:0] quotient,
    output logic signed [fxdiv_pkg::DATA_WIDTH-1:0] remainder,
    output logic                                    div_by_zero
);

    fxdiv_pkg::result_kind_t kind;

    logic [fxdiv_pkg::DATA_WIDTH-1:0] quo_low;
    logic [fxdiv_pkg::DATA_WIDTH-1:0] quo_next;
    logic [fxdiv_pkg::DATA_WIDTH-1:0] rem_next;
    logic [fxdiv_pkg::DATA_WIDTH-1:0] sat_value;

    assign quo_low   = div_bus.quotient_mag[fxdiv_pkg::DATA_WIDTH-1:0];
    assign sat_value = div_bus.negate_quotient ?
                       {1'b1, {(fxdiv_pkg::DATA_WIDTH-1){1'b0}}} :
                       {1'b0, {(fxdiv_pkg::DATA_WIDTH-1){1'b1}}};

    always_comb begin
        if (div_bus.divisor_mag == '0) begin
            kind = fxdiv_pkg::res_zero_div;
        end else if (div_bus.negate_quotient ?
                     div_bus.quotient_mag > fxdiv_pkg::NEG_LIMIT :
                     div_bus.quotient_mag > fxdiv_pkg::POS_LIMIT) begin
            kind = fxdiv_pkg::res_saturate;
        end else begin
            kind = fxdiv_pkg::res_normal;
        end

        case (kind)
            fxdiv_pkg::res_normal: quo_next = div_bus.negate_quotient ? -quo_low : quo_low;
            default:               quo_next = sat_value;
        endcase

        if (kind == fxdiv_pkg::res_zero_div) begin
            rem_next = '0;
        end else begin
            rem_next = div_bus.negate_remainder ? -div_bus.remainder_mag : div_bus.remainder_mag;
        end
    end

    // ************************************************************************
    // Output registers, held until the next result
    // ************************************************************************

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_out   <= 1'b0;
            quotient    <= '0;
            remainder   <= '0;
            div_by_zero <= 1'b0;
        end else begin
            valid_out <= div_bus.done;
            if (div_bus.done) begin
                quotient    <= quo_next;
                remainder   <= rem_next;
                div_by_zero <= (kind == fxdiv_pkg::res_zero_div);
            end
        end
    end

endmodule

/* src/fxdiv_top.sv */
`timescale 1ns/1ns

module fxdiv_top (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    valid_in,
    input  logic signed [fxdiv_pkg::DATA_WIDTH-1:0] dividend,
    input  logic signed [fxdiv_pkg::DATA_WIDTH-1:0] divisor,
    output logic                                    busy,
    output logic                                    valid_out,
    output logic signed [fxdiv_pkg::DATA_WIDTH-1:0] quotient,
    output logic signed [fxdiv_pkg::DATA_WIDTH-1:0] remainder,
    output logic                                    div_by_zero
);

    // ************************************************************************
    // Prep -> core -> format, one division in flight
    // ************************************************************************

    div_if div_bus ();

    operand_prep prep0 (
        .clock     (clock),
        .reset     (reset),
        .valid_in  (valid_in),
        .dividend  (dividend),
        .divisor   (divisor),
        .valid_out (valid_out),      // Ends the busy window
        .busy      (busy),
        .div_bus   (div_bus.prep)
    );

    nonrestoring_divider core0 (
        .clock   (clock),
        .reset   (reset),
        .div_bus (div_bus.core)
    );

    result_format format0 (
        .clock       (clock),
        .reset       (reset),
        .div_bus     (div_bus.format),
        .valid_out   (valid_out),
        .quotient    (quotient),
        .remainder   (remainder),
        .div_by_zero (div_by_zero)
    );

endmodule

/* verification/fxdiv_assert.sv */
`timescale 1ns/1ns

module fxdiv_assert (
    input logic                                    clock,
    input logic                                    reset,
    input logic                                    valid_in,
    input logic signed [fxdiv_pkg::DATA_WIDTH-1:0] dividend,
    input logic signed [fxdiv_pkg::DATA_WIDTH-1:0] divisor,
    input logic                                    busy,
    input logic                                    valid_out,
    input logic signed [fxdiv_pkg::DATA_WIDTH-1:0] quotient,
    input logic signed [fxdiv_pkg::DATA_WIDTH-1:0] remainder,
    input logic                                    div_by_zero
);

    int error_count = 0;

    logic                                    seen_accept;
    logic                                    in_flight;
    int                                      elapsed;   // Edges since the accepting edge
    logic signed [fxdiv_pkg::DATA_WIDTH-1:0] a_cap;
    logic signed [fxdiv_pkg::DATA_WIDTH-1:0] b_cap;
    logic signed [fxdiv_pkg::DATA_WIDTH-1:0] exp_quotient;
    logic signed [fxdiv_pkg::DATA_WIDTH-1:0] exp_remainder;
    logic                                    exp_div_by_zero;
    longint                                  scaled;
    longint                                  quo_full;
    longint                                  limit;

    // ************************************************************************
    // Reference model
    // ************************************************************************

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            seen_accept <= 1'b0;
            in_flight   <= 1'b0;
            elapsed     <= 0;
            a_cap       <= '0;
            b_cap       <= '0;
        end else if (in_flight) begin
            if (elapsed == fxdiv_pkg::LATENCY) begin
                in_flight <= 1'b0;              // Result edge ends the window
            end else begin
                elapsed <= elapsed + 1;
            end
        end else if (valid_in) begin
            seen_accept <= 1'b1;
            in_flight   <= 1'b1;
            elapsed     <= 1;
            a_cap       <= dividend;
            b_cap       <= divisor;
        end
    end

    always_comb begin
        scaled          = longint'(a_cap) * (longint'(1) << fxdiv_pkg::QUANTIZED_BITS);
        limit           = longint'(1) << (fxdiv_pkg::DATA_WIDTH - 1);
        exp_div_by_zero = (b_cap == 0);
        exp_remainder   = '0;
        if (b_cap == 0) begin
            quo_full = a_cap[fxdiv_pkg::DATA_WIDTH-1] ? -limit : limit;
        end else begin
            quo_full      = scaled / longint'(b_cap);      // Truncates toward zero
            exp_remainder = fxdiv_pkg::DATA_WIDTH'(scaled % longint'(b_cap));
        end
        if (quo_full > limit - 1) begin
            quo_full = limit - 1;
        end else if (quo_full < -limit) begin
            quo_full = -limit;
        end
        exp_quotient = fxdiv_pkg::DATA_WIDTH'(quo_full);
    end

    // ************************************************************************
    // Checks
    // ************************************************************************

    idle_after_reset: assert property (@(posedge clock) disable iff (reset)
        !seen_accept |-> !busy && !valid_out && !div_by_zero)
        else begin
            error_count++;
            $error("Error at %0t: busy/valid_out/div_by_zero expected 000 got %b%b%b", $time,
                   $sampled(busy), $sampled(valid_out), $sampled(div_by_zero));
        end

    result_latency: assert property (@(posedge clock) disable iff (reset)
        valid_out == (in_flight && elapsed == fxdiv_pkg::LATENCY))
        else begin
            error_count++;
            $error("Error at %0t: valid_out expected %b got %b", $time,
                   !$sampled(valid_out), $sampled(valid_out));
        end

    busy_window: assert property (@(posedge clock) disable iff (reset)
        busy == in_flight)
        else begin
            error_count++;
            $error("Error at %0t: busy expected %b got %b", $time,
                   $sampled(in_flight), $sampled(busy));
        end

    quotient_value: assert property (@(posedge clock) disable iff (reset)
        valid_out |-> quotient == exp_quotient)
        else begin
            error_count++;
            $error("Error at %0t: quotient expected %0d got %0d", $time,
                   $sampled(exp_quotient), $sampled(quotient));
        end

    remainder_value: assert property (@(posedge clock) disable iff (reset)
        valid_out |-> remainder == exp_remainder)
        else begin
            error_count++;
            $error("Error at %0t: remainder expected %0d got %0d", $time,
                   $sampled(exp_remainder), $sampled(remainder));
        end

    zero_flag_value: assert property (@(posedge clock) disable iff (reset)
        valid_out |-> div_by_zero == exp_div_by_zero)
        else begin
            error_count++;
            $error("Error at %0t: div_by_zero expected %b got %b", $time,
                   $sampled(exp_div_by_zero), $sampled(div_by_zero));
        end

endmodule

/* verification/fxdiv_tb.sv */
`timescale 1ns/1ns

module fxdiv_tb;

    logic                                    clock;
    logic                                    reset;
    logic                                    valid_in;
    logic signed [fxdiv_pkg::DATA_WIDTH-1:0] dividend;
    logic signed [fxdiv_pkg::DATA_WIDTH-1:0] divisor;
    logic                                    busy;
    logic                                    valid_out;
    logic signed [fxdiv_pkg::DATA_WIDTH-1:0] quotient;
    logic signed [fxdiv_pkg::DATA_WIDTH-1:0] remainder;
    logic                                    div_by_zero;
    int                                      timeouts;

    fxdiv_top dut0 (.*);

    bind fxdiv_top fxdiv_assert assert0 (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Waits for a result pulse or for the idle level, sampled on the falling edge
    task automatic wait_for(input bit for_result);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while ((for_result ? !valid_out : busy) && cycles < fxdiv_pkg::LATENCY + 20) begin
            @(negedge clock);
            cycles++;
        end
        if (for_result ? !valid_out : busy) begin
            timeouts++;
            $display("Timeout at %0t: no %s after %0d cycles", $time,
                     for_result ? "valid_out pulse" : "return to idle", cycles);
        end
    endtask

    task automatic strobe(input logic signed [fxdiv_pkg::DATA_WIDTH-1:0] a,
                          input logic signed [fxdiv_pkg::DATA_WIDTH-1:0] b);
        @(posedge clock);
        valid_in <= 1'b1;
        dividend <= a;
        divisor  <= b;
        @(posedge clock);
        valid_in <= 1'b0;
    endtask

    task automatic divide(input logic signed [fxdiv_pkg::DATA_WIDTH-1:0] a,
                          input logic signed [fxdiv_pkg::DATA_WIDTH-1:0] b);
        wait_for(1'b0);
        strobe(a, b);
        wait_for(1'b1);
    endtask

    // Sign pattern cycles through all four combinations
    task automatic random_divisions(input int count);
        logic signed [fxdiv_pkg::DATA_WIDTH-1:0] a;
        logic signed [fxdiv_pkg::DATA_WIDTH-1:0] b;
        for (int i = 0; i < count; i++) begin
            a = $urandom >> $urandom_range(1, 31);
            b = $urandom >> $urandom_range(1, 31);
            if (b == 0) begin
                b = 1;
            end
            if (i[0]) begin
                a = -a;
            end
            if (i[1]) begin
                b = -b;
            end
            divide(a, b);
        end
    endtask

    initial begin
        void'($urandom(37));
        reset    = 1'b1;
        valid_in = 1'b0;
        dividend = '0;
        divisor  = '0;
        timeouts = 0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        repeat (5) @(posedge clock);        // Idle window after reset

        divide(32'sd2560, 32'sd1280);       // 2.5 / 1.25
        divide(-32'sd2560, 32'sd1280);
        divide(32'sd2560, -32'sd1280);
        divide(-32'sd2560, -32'sd1280);
        random_divisions(24);

        // Second strobe lands while busy
        wait_for(1'b0);
        strobe(32'sd7168, 32'sd2048);
        repeat (3) @(posedge clock);
        strobe(32'sd100, 32'sd3);
        wait_for(1'b1);
        repeat (fxdiv_pkg::LATENCY + 4) @(posedge clock);

        divide(32'sh4000_0000, 32'sd1);     // Saturation
        divide(-32'sh4000_0000, 32'sd1);
        divide(32'sh4000_0000, -32'sd3);
        divide(32'sh8000_0000, -32'sd1024); // Most negative over -1.0

        divide(32'sd1000, 32'sd0);
        divide(-32'sd1000, 32'sd0);
        divide(32'sd3072, 32'sd1024);       // Flag clears
        wait_for(1'b0);

        $display("Assertion errors: %0d, timeout errors: %0d",
                 dut0.assert0.error_count, timeouts);
        if (dut0.assert0.error_count + timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
src/fxdiv_pkg.sv
src/div_if.sv
src/operand_prep.sv
src/nonrestoring_divider.sv
src/result_format.sv
src/fxdiv_top.sv
verification/fxdiv_assert.sv
verification/fxdiv_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module fxdiv_tb \
		-Mdir obj_dir -o fxdiv_sim

run: compile
	./obj_dir/fxdiv_sim +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "FAIL: run did not complete"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
